/* compile.f */
+incdir+tests
hw/sm3_expnd_pkg.sv
hw/expnd_ctrl.sv
hw/word_window.sv
hw/word_expander.sv
hw/sm3_expnd_top.sv
tests/tb_sm3_expnd.sv

/* hw/expnd_ctrl.sv */
`timescale 1ns/1ps

module expnd_ctrl
    import sm3_expnd_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    input  logic        pad_vld_i,
    input  logic        pad_lst_i,
    output logic        pad_rdy_o,

    output window_cmd_e win_cmd_o,
    output logic        expnd_vld_o,
    output logic        expnd_lst_o
);

    expnd_state_e state_q;
    expnd_state_e state_d;

    logic [3:0] word_cnt_q;   // message words taken in this block
    logic [5:0] rnd_cnt_q;    // expansion cycles done
    logic       lst_flg_q;

    logic xfer;
    logic head_done;
    logic blk_done;
    logic rnd_done;

    ////////////////////////////////
    // handshake and events
    ////////////////////////////////

    assign pad_rdy_o = (state_q != ST_EXPAND);   // stall only while expanding
    assign xfer      = pad_vld_i & pad_rdy_o;

    assign head_done = xfer && (word_cnt_q == 4'(HEAD_WORDS - 1));
    assign blk_done  = xfer && (word_cnt_q == 4'(WORDS_PER_BLOCK - 1));
    assign rnd_done  = (state_q == ST_EXPAND) && (rnd_cnt_q == 6'(EXPAND_ROUNDS - 1));

    ////////////////////////////////
    // state machine
    ////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (xfer) begin
                    state_d = ST_LOAD_HEAD;   // word 0 in
                end
            end
            ST_LOAD_HEAD: begin
                if (head_done) begin
                    state_d = ST_LOAD_STREAM;
                end
            end
            ST_LOAD_STREAM: begin
                if (blk_done) begin
                    state_d = ST_EXPAND;
                end
            end
            ST_EXPAND: begin
                if (rnd_done) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    ////////////////////////////////
    // counters
    ////////////////////////////////

    // wraps 15 -> 0 at the end of each block
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_cnt_q <= '0;
        end else if (xfer) begin
            word_cnt_q <= word_cnt_q + 4'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rnd_cnt_q <= '0;
        end else if (rnd_done) begin
            rnd_cnt_q <= '0;
        end else if (state_q == ST_EXPAND) begin
            rnd_cnt_q <= rnd_cnt_q + 6'd1;
        end
    end

    // any lst beat marks the whole block
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lst_flg_q <= 1'b0;
        end else if (xfer && pad_lst_i) begin
            lst_flg_q <= 1'b1;
        end else if (rnd_done) begin
            lst_flg_q <= 1'b0;
        end
    end

    ////////////////////////////////
    // outputs
    ////////////////////////////////

    always_comb begin
        if (state_q == ST_EXPAND) begin
            win_cmd_o = WIN_EXPAND;
        end else if (xfer) begin
            win_cmd_o = WIN_LOAD;
        end else begin
            win_cmd_o = WIN_HOLD;
        end
    end

    // streaming pairs follow the input valid
    assign expnd_vld_o = ((state_q == ST_LOAD_STREAM) && pad_vld_i) || (state_q == ST_EXPAND);
    assign expnd_lst_o = lst_flg_q & rnd_done;   // pair 63 only

endmodule

/* hw/sm3_expnd_pkg.sv */
package sm3_expnd_pkg;

    ////////////////////////////////
    // types
    ////////////////////////////////

    typedef logic [31:0] sm3_word_t;

    // one message word on the input side
    typedef struct packed {
        sm3_word_t word;
        logic      lst;   // word belongs to last block of the message
    } pad_beat_t;

    // one expansion output pair
    typedef struct packed {
        sm3_word_t wj;
        sm3_word_t wjj;   // wj ^ w(j+4)
        logic      lst;   // only on pair 63 of a last block
    } expnd_pair_t;

    typedef enum logic [1:0] {
        WIN_HOLD   = 2'd0,
        WIN_LOAD   = 2'd1,   // shift in the input word
        WIN_EXPAND = 2'd2    // shift in the expanded word
    } window_cmd_e;

    typedef enum logic [1:0] {
        ST_IDLE        = 2'd0,
        ST_LOAD_HEAD   = 2'd1,   // words 0..4, no output yet
        ST_LOAD_STREAM = 2'd2,   // words 5..15, pairs 0..10
        ST_EXPAND      = 2'd3    // pairs 11..63, input stalled
    } expnd_state_e;

    ////////////////////////////////
    // constants
    ////////////////////////////////

    localparam int unsigned WORDS_PER_BLOCK = 16;
    localparam int unsigned HEAD_WORDS      = 5;
    localparam int unsigned EXPAND_ROUNDS   = 53;   // j = 11..63

    // rotation amounts of the recurrence
    localparam int unsigned ROT_P1_A  = 15;
    localparam int unsigned ROT_P1_B  = 23;
    localparam int unsigned ROT_MSG_A = 15;
    localparam int unsigned ROT_MSG_B = 7;

    localparam int unsigned WJJ_TAP = 4;   // distance wj to its xor partner

endpackage

/* hw/sm3_expnd_top.sv */
`timescale 1ns/1ps

module sm3_expnd_top
    import sm3_expnd_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    input  pad_beat_t   pad_beat_i,
    input  logic        pad_vld_i,
    output logic        pad_rdy_o,

    output expnd_pair_t expnd_pair_o,
    output logic        expnd_vld_o
);

    window_cmd_e                     win_cmd;
    sm3_word_t [WORDS_PER_BLOCK-1:0] taps;
    sm3_word_t                       new_word;
    sm3_word_t                       wj;
    sm3_word_t                       wjj;
    logic                            expnd_lst;

    ////////////////////////////////
    // control
    ////////////////////////////////

    expnd_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .pad_vld_i   (pad_vld_i),
        .pad_lst_i   (pad_beat_i.lst),
        .pad_rdy_o   (pad_rdy_o),
        .win_cmd_o   (win_cmd),
        .expnd_vld_o (expnd_vld_o),
        .expnd_lst_o (expnd_lst)
    );

    ////////////////////////////////
    // datapath
    ////////////////////////////////

    word_window u_window (
        .clk           (clk),
        .rst_n         (rst_n),
        .win_cmd_i     (win_cmd),
        .load_word_i   (pad_beat_i.word),
        .expand_word_i (new_word),
        .taps_o        (taps)
    );

    word_expander u_expander (
        .taps_i     (taps),
        .new_word_o (new_word),
        .wj_o       (wj),
        .wjj_o      (wjj)
    );

    assign expnd_pair_o = '{wj: wj, wjj: wjj, lst: expnd_lst};

endmodule

/* hw/word_expander.sv */
`timescale 1ns/1ps

module word_expander
    import sm3_expnd_pkg::*;
(
    input  sm3_word_t [WORDS_PER_BLOCK-1:0]  taps_i,
    output sm3_word_t                        new_word_o,
    output sm3_word_t                        wj_o,
    output sm3_word_t                        wjj_o
);

    sm3_word_t p1_in;

    function automatic sm3_word_t rotl(sm3_word_t x, int unsigned n);
        rotl = (x << n) | (x >> ($bits(sm3_word_t) - n));
    endfunction

    function automatic sm3_word_t p1(sm3_word_t x);
        p1 = x ^ rotl(x, ROT_P1_A) ^ rotl(x, ROT_P1_B);
    endfunction

    ////////////////////////////////
    // recurrence
    ////////////////////////////////

    // taps 0, 7, 13 are w(j-16), w(j-9), w(j-3)
    assign p1_in = taps_i[0] ^ taps_i[7] ^ rotl(taps_i[13], ROT_MSG_A);

    // taps 3, 10 are w(j-13), w(j-6)
    assign new_word_o = p1(p1_in) ^ rotl(taps_i[3], ROT_MSG_B) ^ taps_i[10];

    ////////////////////////////////
    // output pair
    ////////////////////////////////

    // wj sits WJJ_TAP below the newest word
    assign wj_o  = taps_i[WORDS_PER_BLOCK-1-WJJ_TAP];
    assign wjj_o = taps_i[WORDS_PER_BLOCK-1-WJJ_TAP] ^ taps_i[WORDS_PER_BLOCK-1];

endmodule

/* hw/word_window.sv */
`timescale 1ns/1ps

module word_window
    import sm3_expnd_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst_n,

    input  window_cmd_e                      win_cmd_i,
    input  sm3_word_t                        load_word_i,
    input  sm3_word_t                        expand_word_i,

    output sm3_word_t [WORDS_PER_BLOCK-1:0]  taps_o
);

    // index 0 holds the oldest word, 15 the newest
    sm3_word_t [WORDS_PER_BLOCK-1:0] win_q;
    sm3_word_t                       push_word;
    logic                            shift_en;

    ////////////////////////////////
    // word select
    ////////////////////////////////

    always_comb begin
        case (win_cmd_i)
            WIN_EXPAND: push_word = expand_word_i;
            default:    push_word = load_word_i;   // load, or don't care on hold
        endcase
    end

    assign shift_en = (win_cmd_i == WIN_LOAD) || (win_cmd_i == WIN_EXPAND);

    ////////////////////////////////
    // shift register
    ////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_q <= '0;
        end else if (shift_en) begin
            // drop index 0, new word lands at the top
            win_q <= {push_word, win_q[WORDS_PER_BLOCK-1:1]};
        end
    end

    assign taps_o = win_q;

endmodule

/* tests/sm3_ref_model.svh */
`ifndef SM3_REF_MODEL_SVH
`define SM3_REF_MODEL_SVH

localparam int NUM_BLOCKS = 8;

typedef logic [67:0][31:0] word_seq_t;   // w0..w67 of one block

// one idle valid cycle before word i when gap_mask[i] is set
typedef struct packed {
    logic [15:0][31:0] words;
    logic              lst;
    logic [15:0]       gap_mask;
} block_row_t;

// padded "abc" message with word 0 at the low end
localparam logic [15:0][31:0] ABC_BLOCK = {32'h00000018, {14{32'h0}}, 32'h61626380};

block_row_t block_tbl [NUM_BLOCKS];

function automatic logic [31:0] rotl32(logic [31:0] x, int n);
    return (x << n) | (x >> (32 - n));
endfunction

function automatic logic [31:0] p1_perm(logic [31:0] x);
    return x ^ rotl32(x, 15) ^ rotl32(x, 23);
endfunction

function automatic word_seq_t expand_message(logic [15:0][31:0] msg);
    word_seq_t w;
    for (int j = 0; j < 16; j++) begin
        w[j] = msg[j];
    end
    for (int j = 16; j < 68; j++) begin
        w[j] = p1_perm(w[j-16] ^ w[j-9] ^ rotl32(w[j-3], 15)) ^ rotl32(w[j-13], 7) ^ w[j-6];
    end
    return w;
endfunction

`endif

/* tests/tb_sm3_expnd.sv */
`timescale 1ns/1ps

module tb_sm3_expnd
    import sm3_expnd_pkg::*;
();

    localparam int RESET_CYCLES = 3;

    `include "sm3_ref_model.svh"

    logic        clk;
    logic        rst_n;
    pad_beat_t   pad_beat_i;
    logic        pad_vld_i;
    logic        pad_rdy_o;
    expnd_pair_t expnd_pair_o;
    logic        expnd_vld_o;

    expnd_pair_t exp_q [$];   // pairs still owed by the DUT
    int          err_cnt;
    int          chk_cnt;
    int          cycle_cnt;
    int          cycle_limit;
    logic [31:0] lcg_state;
    int          word_idx;    // transfers seen in the current block
    int          stall_cnt;
    logic        in_expand;

    sm3_expnd_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .pad_beat_i   (pad_beat_i),
        .pad_vld_i    (pad_vld_i),
        .pad_rdy_o    (pad_rdy_o),
        .expnd_pair_o (expnd_pair_o),
        .expnd_vld_o  (expnd_vld_o)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    ///////////////////////////////
    // helpers
    ///////////////////////////////

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("** Error: %s got %08h expected %08h at %0t", name, got, exp, $time);
        end
    endtask

    task report_failure(input string msg);
        err_cnt++;
        $display("%0t: %s", $time, msg);
    endtask

    task fill_table();
        logic [31:0] r;
        block_tbl[0] = '{words: ABC_BLOCK, lst: 1'b1, gap_mask: 16'h0000};
        block_tbl[1] = '{words: {16{32'hffffffff}}, lst: 1'b0, gap_mask: 16'hffff};
        for (int b = 2; b < NUM_BLOCKS; b++) begin
            for (int i = 0; i < 16; i++) begin
                block_tbl[b].words[i] = lcg_next();
            end
            r = lcg_next();
            block_tbl[b].lst      = (b % 2 == 1);
            block_tbl[b].gap_mask = r[23:8] & r[31:16];   // sparse gaps
        end
        cycle_limit = 0;
        for (int b = 0; b < NUM_BLOCKS; b++) begin
            cycle_limit += 2 * (16 + 53 + $countones(block_tbl[b].gap_mask));
        end
    endtask

    task idle_cycle();
        pad_vld_i <= 1'b0;
        @(posedge clk);
    endtask

    // holds the beat until ready is seen, returns on the transfer edge
    task send_word(input logic [31:0] data, input logic last);
        pad_beat_i <= '{word: data, lst: last};
        pad_vld_i  <= 1'b1;
        @(negedge clk);
        while (!pad_rdy_o) @(negedge clk);
        @(posedge clk);
    endtask

    task send_block(input block_row_t row);
        word_seq_t w;
        w = expand_message(row.words);
        for (int j = 0; j < 64; j++) begin
            exp_q.push_back(expnd_pair_t'{wj: w[j], wjj: w[j] ^ w[j+4],
                                          lst: row.lst && (j == 63)});
        end
        for (int i = 0; i < 16; i++) begin
            if (row.gap_mask[i]) idle_cycle();
            send_word(row.words[i], row.lst);
        end
    endtask

    ///////////////////////////////
    // monitor
    ///////////////////////////////

    always @(negedge clk) begin : pair_monitor
        expnd_pair_t exp_pair;
        logic        xfer;
        if (rst_n === 1'b1) begin
            xfer = pad_vld_i && pad_rdy_o;
            if (in_expand) begin
                if (pad_rdy_o) begin
                    if (stall_cnt != EXPAND_ROUNDS) begin
                        report_failure($sformatf("ready was low for %0d cycles, not 53",
                                                 stall_cnt));
                    end
                    in_expand = 1'b0;
                end else begin
                    stall_cnt++;
                    if (!expnd_vld_o) report_failure("no valid pair in an expansion cycle");
                end
            end
            if (!in_expand) begin
                if (!pad_rdy_o) report_failure("ready low outside the expansion phase");
                if (xfer) begin
                    if (word_idx < HEAD_WORDS && expnd_vld_o) begin
                        report_failure("valid pair during the first five words of a block");
                    end else if (word_idx >= HEAD_WORDS && !expnd_vld_o) begin
                        report_failure("no pair for a streamed message word");
                    end
                    word_idx++;
                    if (word_idx == WORDS_PER_BLOCK) begin
                        word_idx  = 0;
                        stall_cnt = 0;
                        in_expand = 1'b1;
                    end
                end else if (expnd_vld_o) begin
                    report_failure("valid pair without an input transfer");
                end
            end
            if (expnd_vld_o) begin
                if (exp_q.size() == 0) begin
                    report_failure("valid pair when none is expected");
                end else begin
                    exp_pair = exp_q.pop_front();
                    check_value("expnd_pair_o.wj", expnd_pair_o.wj, exp_pair.wj);
                    check_value("expnd_pair_o.wjj", expnd_pair_o.wjj, exp_pair.wjj);
                    check_value("expnd_pair_o.lst", 32'(expnd_pair_o.lst), 32'(exp_pair.lst));
                end
            end
        end
    end

    initial begin : watchdog
        cycle_cnt = 0;
        do begin
            @(posedge clk);
            cycle_cnt++;
        end while (cycle_cnt < cycle_limit);
        $display("timeout after %0d cycles, the run did not complete", cycle_cnt);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin : main_seq
        word_seq_t abc_w;
        err_cnt    = 0;
        chk_cnt    = 0;
        word_idx   = 0;
        stall_cnt  = 0;
        in_expand  = 1'b0;
        lcg_state  = 32'hf76c;
        rst_n      = 1'b0;
        pad_vld_i  = 1'b0;
        pad_beat_i = '0;
        fill_table();

        // model against the published abc expansion
        abc_w = expand_message(ABC_BLOCK);
        check_value("model w16", abc_w[16], 32'h9092e200);
        check_value("model w18", abc_w[18], 32'h000c0606);

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("pad_rdy_o", 32'(pad_rdy_o), 32'h1);
        check_value("expnd_vld_o", 32'(expnd_vld_o), 32'h0);
        @(posedge clk);

        for (int b = 0; b < NUM_BLOCKS; b++) begin
            send_block(block_tbl[b]);
        end
        pad_vld_i <= 1'b0;
        while (exp_q.size() != 0 || in_expand) @(negedge clk);

        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
